// ==== busPkg.sv ====
package busPkg;

	// mmio bus widths
	localparam int AddrWidth = 16;
	localparam int DataWidth = 32;

	typedef logic [AddrWidth-1:0] addrT;
	typedef logic [DataWidth-1:0] dataT;

	// host operation codes
	typedef enum logic [1:0]
	{
		OpIdle  = 2'd0,
		OpRead  = 2'd1,
		OpWrite = 2'd2
	} busOpT;

	// hub request tracking
	typedef enum logic [1:0]
	{
		HubIdle = 2'd0,
		HubWait = 2'd1,
		HubResp = 2'd2
	} hubStateT;

	// cycles without a claim before the hub gives up on a request
	localparam int MissLimit = 16;

endpackage

// ==== periphPkg.sv ====
package periphPkg;

	import busPkg::*;

	// block bases, one 256-byte block each
	localparam addrT GpioBase  = 16'hE000;
	localparam addrT TimerBase = 16'hE100;
	localparam addrT BlockMask = 16'hFF00;

	// gpio offsets
	localparam addrT RegOutOfs = 16'h0000;
	localparam addrT RegInOfs  = 16'h0004;

	// timer offsets
	localparam addrT RegUsecOfs = 16'h0000;
	localparam addrT RegMsecOfs = 16'h0004;
	localparam addrT RegStatOfs = 16'h0008;

	// register widths
	localparam int GpioWidth  = 16;
	localparam int CountWidth = 32;

	typedef logic [GpioWidth-1:0]  gpioT;
	typedef logic [CountWidth-1:0] countT;

endpackage

// ==== mmioBus_if.sv ====
`timescale 1ns/1ps

interface mmioBus_if import busPkg::*; ();

	// request side, driven by the hub
	logic  strobe;
	busOpT op;
	addrT  addr;
	dataT  wdata;

	// response side, driven by the claiming peripheral
	logic  ack;
	dataT  rdata;

	modport hub
	(
		output strobe,
		output op,
		output addr,
		output wdata,
		input  ack,
		input  rdata
	);

	modport periph
	(
		input  strobe,
		input  op,
		input  addr,
		input  wdata,
		output ack,
		output rdata
	);

endinterface

// ==== tickGen.sv ====
`timescale 1ns/1ps

module tickGen #(
	parameter int ClkPerUs = 50,
	parameter int UsPerMs  = 1000
) (
	input  logic clock,
	input  logic rstN_i,
	output logic tickUs_o,
	output logic tickMs_o
);

	localparam int DivW = $clog2(ClkPerUs + 1);
	localparam int UsW  = $clog2(UsPerMs + 1);

	logic [DivW-1:0] divCnt;
	logic [UsW-1:0]  usCnt;
	logic            usWrap;
	logic            msWrap;

	assign usWrap = (divCnt == DivW'(ClkPerUs - 1));
	assign msWrap = (usCnt == UsW'(UsPerMs - 1));

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			divCnt   <= '0;
			usCnt    <= '0;
			tickUs_o <= 1'b0;
			tickMs_o <= 1'b0;
		end
		else
		begin
			tickUs_o <= usWrap;
			// ms tick rides on the us tick that closes the count
			tickMs_o <= usWrap && msWrap;

			if (usWrap)
				divCnt <= '0;
			else
				divCnt <= divCnt + 1'b1;

			if (usWrap)
			begin
				if (msWrap)
					usCnt <= '0;
				else
					usCnt <= usCnt + 1'b1;
			end
		end
	end

endmodule

// ==== gpioRegs.sv ====
`timescale 1ns/1ps

module gpioRegs import busPkg::*, periphPkg::*; (
	input  logic             clock,
	input  logic             rstN_i,
	mmioBus_if.periph        bus,
	input  gpioT             gpioPins_i,
	output gpioT             gpioPins_o
);

	gpioT pinSync1;
	gpioT pinSync2;
	gpioT outReg;

	logic hit;
	addrT regOfs;
	dataT rdataNext;
	logic ackReg;
	dataT rdataReg;

	// own block only, the hub broadcasts everything
	assign hit    = bus.strobe && ((bus.addr & BlockMask) == GpioBase);
	assign regOfs = bus.addr & ~BlockMask;

	// two-flop input synchronizer
	always_ff @(posedge clock)
	begin
		pinSync1 <= gpioPins_i;
		pinSync2 <= pinSync1;
	end

	always_comb
	begin
		case (regOfs)
			RegOutOfs: rdataNext = dataT'(outReg);
			RegInOfs:  rdataNext = dataT'(pinSync2);
			default:   rdataNext = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			ackReg <= 1'b0;
			outReg <= '0;
		end
		else
		begin
			ackReg <= hit;
			if (hit && (bus.op == OpWrite) && (regOfs == RegOutOfs))
				outReg <= bus.wdata[GpioWidth-1:0];
		end
	end

	// read data only matters in the ack cycle
	always_ff @(posedge clock)
	begin
		if (hit)
			rdataReg <= rdataNext;
	end

	assign bus.ack    = ackReg;
	assign bus.rdata  = rdataReg;
	assign gpioPins_o = outReg;

endmodule

// ==== timerRegs.sv ====
`timescale 1ns/1ps

module timerRegs import busPkg::*, periphPkg::*; (
	input  logic      clock,
	input  logic      rstN_i,
	mmioBus_if.periph bus,
	input  logic      tickUs_i,
	input  logic      tickMs_i,
	output logic      irq_o
);

	countT usecCnt;
	countT msecCnt;
	logic  irqPend;
	logic  tickMsDly;
	logic  msRise;

	logic  hit;
	addrT  regOfs;
	logic  clrReq;
	dataT  rdataNext;
	logic  ackReg;
	dataT  rdataReg;

	assign hit    = bus.strobe && ((bus.addr & BlockMask) == TimerBase);
	assign regOfs = bus.addr & ~BlockMask;
	assign clrReq = hit && (bus.op == OpWrite) && (regOfs == RegStatOfs) && bus.wdata[0];
	assign msRise = tickMs_i && !tickMsDly;

	always_comb
	begin
		case (regOfs)
			RegUsecOfs: rdataNext = dataT'(usecCnt);
			RegMsecOfs: rdataNext = dataT'(msecCnt);
			RegStatOfs: rdataNext = dataT'(irqPend);
			default:    rdataNext = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			usecCnt   <= '0;
			msecCnt   <= '0;
			irqPend   <= 1'b0;
			tickMsDly <= 1'b0;
			ackReg    <= 1'b0;
		end
		else
		begin
			ackReg    <= hit;
			tickMsDly <= tickMs_i;
			if (tickUs_i)
				usecCnt <= usecCnt + 1'b1;
			if (tickMs_i)
				msecCnt <= msecCnt + 1'b1;
			// a new tick beats a clear in the same cycle
			if (msRise)
				irqPend <= 1'b1;
			else if (clrReq)
				irqPend <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (hit)
			rdataReg <= rdataNext;
	end

	assign bus.ack   = ackReg;
	assign bus.rdata = rdataReg;
	assign irq_o     = irqPend;

endmodule

// ==== mmioHub.sv ====
`timescale 1ns/1ps

module mmioHub import busPkg::*; #(
	parameter int MissCycles = MissLimit
) (
	input  logic   clock,
	input  logic   rstN_i,

	input  logic   reqValid_i,
	output logic   reqReady_o,
	input  busOpT  reqOp_i,
	input  addrT   reqAddr_i,
	input  dataT   reqData_i,

	output logic   respValid_o,
	input  logic   respReady_i,
	output dataT   respData_o,
	output logic   respMiss_o,

	mmioBus_if.hub gpioBus,
	mmioBus_if.hub timerBus
);

	// counter also spans the strobe and ack latency
	localparam int CntW = $clog2(MissCycles + 2);

	hubStateT state;

	busOpT opReg;
	addrT  addrReg;
	dataT  wdataReg;
	logic  issue;
	logic  strobeReg;
	dataT  respDataReg;
	logic  respMissReg;

	logic [CntW-1:0] waitCnt;

	logic accept;
	logic anyAck;
	logic missHit;
	dataT ackData;

	// ready again in the same cycle the response drains
	assign reqReady_o = (state == HubIdle) || ((state == HubResp) && respReady_i);
	assign accept     = reqValid_i && reqReady_o;

	// fixed priority, gpio first
	assign anyAck  = gpioBus.ack || timerBus.ack;
	assign ackData = gpioBus.ack ? gpioBus.rdata : timerBus.rdata;
	assign missHit = (waitCnt == CntW'(MissCycles + 1));

	always_ff @(posedge clock)
	begin
		if (!rstN_i)
		begin
			state     <= HubIdle;
			issue     <= 1'b0;
			strobeReg <= 1'b0;
			waitCnt   <= '0;
		end
		else
		begin
			// strobe goes out one cycle after acceptance, for one cycle
			strobeReg <= issue;
			issue     <= 1'b0;

			if (accept)
			begin
				state   <= HubWait;
				issue   <= 1'b1;
				waitCnt <= '0;
			end
			else
			begin
				case (state)
					HubWait:
					begin
						if (anyAck || missHit)
							state <= HubResp;
						else
							waitCnt <= waitCnt + 1'b1;
					end
					HubResp:
					begin
						if (respReady_i)
							state <= HubIdle;
					end
					default: state <= HubIdle;
				endcase
			end
		end
	end

	// request and response payload
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			opReg    <= reqOp_i;
			addrReg  <= reqAddr_i;
			wdataReg <= reqData_i;
		end

		// frozen once the hub moves to respond
		if (state == HubWait)
		begin
			respDataReg <= anyAck ? ackData : '0;
			respMissReg <= !anyAck;
		end
	end

	assign gpioBus.strobe  = strobeReg;
	assign gpioBus.op      = opReg;
	assign gpioBus.addr    = addrReg;
	assign gpioBus.wdata   = wdataReg;

	assign timerBus.strobe = strobeReg;
	assign timerBus.op     = opReg;
	assign timerBus.addr   = addrReg;
	assign timerBus.wdata  = wdataReg;

	assign respValid_o = (state == HubResp);
	assign respData_o  = respDataReg;
	assign respMiss_o  = respMissReg;

endmodule

// ==== socTop.sv ====
`timescale 1ns/1ps

module socTop import busPkg::*, periphPkg::*; #(
	parameter int ClkPerUs   = 50,
	parameter int UsPerMs    = 1000,
	parameter int MissCycles = MissLimit
) (
	input  logic  clock,
	input  logic  rstN_i,

	input  logic  reqValid_i,
	output logic  reqReady_o,
	input  busOpT reqOp_i,
	input  addrT  reqAddr_i,
	input  dataT  reqData_i,

	output logic  respValid_o,
	input  logic  respReady_i,
	output dataT  respData_o,
	output logic  respMiss_o,

	input  gpioT  gpioPins_i,
	output gpioT  gpioPins_o,
	output logic  irq_o
);

	logic tickUs;
	logic tickMs;

	// one bus per peripheral
	mmioBus_if gpioBus ();
	mmioBus_if timerBus ();

	mmioHub #(
		.MissCycles (MissCycles)
	) uHub (
		.clock       (clock),
		.rstN_i      (rstN_i),
		.reqValid_i  (reqValid_i),
		.reqReady_o  (reqReady_o),
		.reqOp_i     (reqOp_i),
		.reqAddr_i   (reqAddr_i),
		.reqData_i   (reqData_i),
		.respValid_o (respValid_o),
		.respReady_i (respReady_i),
		.respData_o  (respData_o),
		.respMiss_o  (respMiss_o),
		.gpioBus     (gpioBus.hub),
		.timerBus    (timerBus.hub)
	);

	tickGen #(
		.ClkPerUs (ClkPerUs),
		.UsPerMs  (UsPerMs)
	) uTickGen (
		.clock    (clock),
		.rstN_i   (rstN_i),
		.tickUs_o (tickUs),
		.tickMs_o (tickMs)
	);

	gpioRegs uGpio (
		.clock      (clock),
		.rstN_i     (rstN_i),
		.bus        (gpioBus.periph),
		.gpioPins_i (gpioPins_i),
		.gpioPins_o (gpioPins_o)
	);

	timerRegs uTimer (
		.clock    (clock),
		.rstN_i   (rstN_i),
		.bus      (timerBus.periph),
		.tickUs_i (tickUs),
		.tickMs_i (tickMs),
		.irq_o    (irq_o)
	);

endmodule

// ==== socTop_assert.sv ====
`timescale 1ns/1ps

module socTop_assert import busPkg::*; (
	input logic  clock,
	input logic  rstN_i,
	input logic  reqValid_i,
	input logic  reqReady_o,
	input busOpT reqOp_i,
	input addrT  reqAddr_i,
	input dataT  reqData_i,
	input logic  respValid_o,
	input logic  respReady_i,
	input dataT  respData_o,
	input logic  respMiss_o,
	input logic  irq_o
);

	// a stalled request must not move
	property reqHeld;
		@(posedge clock) disable iff (!rstN_i)
		(reqValid_i && !reqReady_o) |=>
			(reqValid_i && $stable(reqOp_i) && $stable(reqAddr_i) && $stable(reqData_i));
	endproperty

	property respHeld;
		@(posedge clock) disable iff (!rstN_i)
		(respValid_o && !respReady_i) |=>
			(respValid_o && $stable(respData_o) && $stable(respMiss_o));
	endproperty

	property irqQuietInReset;
		@(posedge clock)
		!rstN_i |=> !irq_o;
	endproperty

	reqHeldA: assert property (reqHeld)
		else $error("host request changed while waiting for reqReady_o");

	respHeldA: assert property (respHeld)
		else $error("response changed while respReady_i was low");

	irqResetA: assert property (irqQuietInReset)
		else $error("irq_o high during reset");

endmodule

bind socTop socTop_assert uAssert (
	.clock       (clock),
	.rstN_i      (rstN_i),
	.reqValid_i  (reqValid_i),
	.reqReady_o  (reqReady_o),
	.reqOp_i     (reqOp_i),
	.reqAddr_i   (reqAddr_i),
	.reqData_i   (reqData_i),
	.respValid_o (respValid_o),
	.respReady_i (respReady_i),
	.respData_o  (respData_o),
	.respMiss_o  (respMiss_o),
	.irq_o       (irq_o)
);

// ==== tb_socTop.sv ====
`timescale 1ns/1ps

module tb_socTop import busPkg::*, periphPkg::*; ();

	localparam int ClkPerUs   = 4;
	localparam int UsPerMs    = 8;
	localparam int MissCycles = 16;
	localparam int IrqTimeout = 2 * ClkPerUs * UsPerMs;
	localparam int WaitLimit  = 100;

	logic  clock;
	logic  rstN_i;
	logic  reqValid_i;
	logic  reqReady_o;
	busOpT reqOp_i;
	addrT  reqAddr_i;
	dataT  reqData_i;
	logic  respValid_o;
	logic  respReady_i;
	dataT  respData_o;
	logic  respMiss_o;
	gpioT  gpioPins_i;
	gpioT  gpioPins_o;
	logic  irq_o;

	int          cycleCnt = 0;
	logic [15:0] lfsr;
	// last value read per address for the non-decreasing rule
	dataT        lastRead [addrT];

	socTop #(
		.ClkPerUs   (ClkPerUs),
		.UsPerMs    (UsPerMs),
		.MissCycles (MissCycles)
	) u_dut (
		.clock       (clock),
		.rstN_i      (rstN_i),
		.reqValid_i  (reqValid_i),
		.reqReady_o  (reqReady_o),
		.reqOp_i     (reqOp_i),
		.reqAddr_i   (reqAddr_i),
		.reqData_i   (reqData_i),
		.respValid_o (respValid_o),
		.respReady_i (respReady_i),
		.respData_o  (respData_o),
		.respMiss_o  (respMiss_o),
		.gpioPins_i  (gpioPins_i),
		.gpioPins_o  (gpioPins_o),
		.irq_o       (irq_o)
	);

	always #10 clock = ~clock;

	always @(posedge clock)
		cycleCnt <= cycleCnt + 1;

	// galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	task automatic takeBits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input dataT expVal, input dataT actVal,
		input dataT mask);
		assert ((actVal & mask) == (expVal & mask))
		else
			stopOnError($sformatf("FAIL %s expected %h actual %h", name, expVal & mask,
				actVal & mask));
	endtask

	task automatic runAccess(input string name, input string opStr, input addrT addr,
		input dataT wdata, input dataT expData, input dataT mask, input logic expMiss);
		int   n;
		int   accEdge;
		int   latency;
		int   expLat;
		int   hold;
		dataT heldData;
		logic heldMiss;

		@(posedge clock);
		#1;
		// write data column doubles as the input pin value
		gpioPins_i = gpioT'(wdata);
		if (opStr == "rd")
		begin
			repeat (3) @(posedge clock);
			#1;
		end
		reqValid_i = 1'b1;
		reqOp_i    = (opStr == "wr") ? OpWrite : OpRead;
		reqAddr_i  = addr;
		reqData_i  = wdata;

		n = 0;
		@(negedge clock);
		while (!reqReady_o)
		begin
			n++;
			assert (n <= WaitLimit)
			else
				stopOnError({name, ": timeout waiting for the request to be accepted"});
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		accEdge    = cycleCnt;
		reqValid_i = 1'b0;

		n = 0;
		@(negedge clock);
		while (!respValid_o)
		begin
			n++;
			assert (n <= WaitLimit)
			else
				stopOnError({name, ": timeout waiting for the response"});
			@(negedge clock);
		end

		// mapped accesses take 3 edges and misses 2 plus the timeout
		latency = cycleCnt - accEdge;
		expLat  = expMiss ? 2 + MissCycles : 3;
		assert (latency == expLat)
		else
			stopOnError($sformatf("FAIL %s latency expected %0d actual %0d", name, expLat,
				latency));
		assert (respMiss_o == expMiss)
		else
			stopOnError($sformatf("FAIL %s miss expected %b actual %b", name, expMiss,
				respMiss_o));

		heldData = respData_o;
		heldMiss = respMiss_o;
		takeBits(3, hold);
		repeat (hold)
		begin
			@(negedge clock);
			assert (respValid_o && (respData_o == heldData) && (respMiss_o == heldMiss))
			else
				stopOnError({name, ": response changed while respReady_i was low"});
		end
		@(posedge clock);
		#1;
		respReady_i = 1'b1;
		@(negedge clock);
		assert (respValid_o && (respData_o == heldData) && (respMiss_o == heldMiss))
		else
			stopOnError({name, ": response dropped before it was accepted"});
		@(posedge clock);
		#1;
		respReady_i = 1'b0;

		// unclaimed requests always return zero data
		if (expMiss)
			checkValue(name, '0, heldData, {DataWidth{1'b1}});

		// with a zero mask the expected column selects a rule where 1 means non-decreasing
		if (mask != '0)
			checkValue(name, expData, heldData, mask);
		else if ((expData == 32'd1) && lastRead.exists(addr))
		begin
			assert (heldData >= lastRead[addr])
			else
				stopOnError($sformatf("FAIL %s expected at least %h actual %h", name,
					lastRead[addr], heldData));
		end
		if (opStr == "rd")
			lastRead[addr] = heldData;
	endtask

	task automatic waitIrq(input string name);
		int n;

		n = 0;
		@(negedge clock);
		while (!irq_o)
		begin
			n++;
			assert (n <= IrqTimeout)
			else
				stopOnError({name, ": timeout waiting for irq_o to rise"});
			@(negedge clock);
		end
	endtask

	task automatic checkIrqQuiet(input string name, input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			assert (!irq_o)
			else
				stopOnError($sformatf("FAIL %s irq_o expected 0 actual %b", name, irq_o));
		end
	endtask

	initial
	begin
		int    fd;
		int    fields;
		int    count;
		int    expMiss;
		string line;
		string name;
		string opStr;
		addrT  addr;
		dataT  wdata;
		dataT  expData;
		dataT  mask;

		clock       = 1'b0;
		rstN_i      = 1'b0;
		reqValid_i  = 1'b0;
		reqOp_i     = OpIdle;
		reqAddr_i   = '0;
		reqData_i   = '0;
		respReady_i = 1'b0;
		gpioPins_i  = '0;
		lfsr        = 16'd26202;

		repeat (10) @(posedge clock);
		#1;
		rstN_i = 1'b1;
		@(negedge clock);
		assert (reqReady_o && !respValid_o && !irq_o && (gpioPins_o == '0))
		else
			stopOnError("outputs are not at their reset values after reset");

		fd = $fopen("mmio_patterns.txt", "r");
		assert (fd != 0)
		else
			stopOnError("cannot open mmio_patterns.txt");

		count = 0;
		while ($fgets(line, fd) != 0)
		begin
			if ((line.len() < 2) || (line.getc(0) == "#"))
				continue;
			fields = $sscanf(line, "%s %s %h %h %h %h %d", name, opStr, addr, wdata,
				expData, mask, expMiss);
			assert (fields == 7)
			else
				stopOnError({"malformed pattern line: ", line});
			case (opStr)
				"rd", "wr": runAccess(name, opStr, addr, wdata, expData, mask, expMiss != 0);
				"po":
				begin
					@(negedge clock);
					checkValue(name, expData, dataT'(gpioPins_o), mask);
				end
				"wirq": waitIrq(name);
				"qirq": checkIrqQuiet(name, int'(wdata));
				default: stopOnError({"unknown operation in the pattern file: ", opStr});
			endcase
			count++;
		end
		$fclose(fd);

		if (count > 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
			stopOnError("no patterns were read");
	end

endmodule

// ==== mmio_patterns.txt ====
# name op addr wdata expected_rdata mask expected_miss, hex except miss
# op rd/wr access, po gpio output pins, wirq wait for irq, qirq irq low for wdata cycles
msecReset     rd   E104 00000000 00000000 FFFFFFFF 0
gpioWrite     wr   E000 1234ABCD 00000000 00000000 0
gpioReadOut   rd   E000 00000000 0000ABCD FFFFFFFF 0
gpioPinsOut   po   0000 00000000 0000ABCD 0000FFFF 0
gpioReadIn    rd   E004 00005A5A 00005A5A FFFFFFFF 0
gpioReadIn2   rd   E004 0000C3F1 0000C3F1 FFFFFFFF 0
gpioWrInReg   wr   E004 0000FFFF 00000000 00000000 0
gpioKeep      rd   E000 00000000 0000ABCD FFFFFFFF 0
gpioWide      wr   E000 FFFF0F0F 00000000 00000000 0
gpioReadWide  rd   E000 00000000 00000F0F FFFFFFFF 0
gpioPinsWide  po   0000 00000000 00000F0F 0000FFFF 0
gpioOther     rd   E0FC 00000000 00000000 FFFFFFFF 0
missRead      rd   E200 00000000 00000000 FFFFFFFF 1
missWrite     wr   1234 DEADBEEF 00000000 00000000 1
missLow       rd   0000 00000000 00000000 FFFFFFFF 1
usec1         rd   E100 00000000 00000001 00000000 0
usec2         rd   E100 00000000 00000001 00000000 0
msec1         rd   E104 00000000 00000001 00000000 0
usecWrite     wr   E100 00000000 00000000 00000000 0
usec3         rd   E100 00000000 00000001 00000000 0
timerOther    rd   E10C 00000000 00000000 FFFFFFFF 0
irqWait       wirq 0000 00000000 00000000 00000000 0
irqStatus     rd   E108 00000000 00000001 00000001 0
irqClear      wr   E108 00000001 00000000 00000000 0
irqFresh      wirq 0000 00000000 00000000 00000000 0
irqClear2     wr   E108 00000001 00000000 00000000 0
irqQuiet      qirq 0000 00000004 00000000 00000000 0
usec4         rd   E100 00000000 00000001 00000000 0
msec2         rd   E104 00000000 00000001 00000000 0

// ==== sources.f ====
busPkg.sv
periphPkg.sv
mmioBus_if.sv
tickGen.sv
gpioRegs.sv
timerRegs.sv
mmioHub.sv
socTop.sv
socTop_assert.sv
tb_socTop.sv

// ==== run.sh ====
#!/bin/sh
# build and run the socTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_socTop -f sources.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_socTop)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
	exit 0
fi

echo "pass message not found in the simulation output"
exit 1
